// ==== logic/id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// datapath widths
`define XLEN   64
`define ILEN   32
`define REG_AW 5
`define NREGS  32

// instruction fields
`define RNG_OPC 6:0
`define RNG_RD  11:7
`define RNG_F3  14:12
`define RNG_RS1 19:15
`define RNG_RS2 24:20
`define RNG_F7  31:25

// major opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011

`define F3_JALR 3'b000

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LD  3'b011
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_LWU 3'b110

`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010
`define F3_SD 3'b011

// shared by OP, OP-IMM and their 32-bit forms
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// upper six bits for RV64 immediate shifts, shamt is 6 bits wide
`define F6_BASE 6'b000000
`define F6_ALT  6'b010000

`endif

// ==== logic/id_pkg.sv ====
`include "id_params.svh"

package id_pkg;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} imm_fmt_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_LUI,
		ALU_AUIPC,
		ALU_BLT,
		ALU_BGE
	} alu_op_t;

	typedef enum logic [1:0] {
		MEM_B,
		MEM_H,
		MEM_W,
		MEM_D
	} mem_size_t;

	typedef struct packed {
		logic              valid;
		imm_fmt_t          fmt;
		alu_op_t           alu_op;
		logic              alu_src_imm;  // second operand is the immediate
		logic              is_branch;    // conditional branches and jumps
		logic              mem_rd;
		logic              mem_wr;
		mem_size_t         mem_size;
		logic              mem_unsigned; // zero extend the load
		logic              rf_wr;
		logic [`REG_AW-1:0] rd_addr;
		logic              word_op;      // 32-bit op, result sign extended
	} id_ctrl_t;

endpackage

// ==== logic/regfile_2r1w.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module regfile_2r1w (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`REG_AW-1:0] i_raddr_a,
	input  logic [`REG_AW-1:0] i_raddr_b,
	input  logic               i_wen,
	input  logic [`REG_AW-1:0] i_waddr,
	input  logic [`XLEN-1:0]   i_wdata,
	output logic [`XLEN-1:0]   o_rdata_a,
	output logic [`XLEN-1:0]   o_rdata_b
);

	logic [`XLEN-1:0] regs [1:`NREGS-1]; // x0 is not stored

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (i_wen && (i_waddr != '0)) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// no write bypass, reads see the current contents
	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module imm_gen import id_pkg::*; (
	input  logic [`ILEN-1:0] i_instr,
	input  imm_fmt_t         i_fmt,
	output logic [`XLEN-1:0] o_imm
);

	logic sign;

	assign sign = i_instr[31];

	always_comb begin
		case (i_fmt)
			FMT_I: o_imm = {{52{sign}}, i_instr[31:20]};
			FMT_S: o_imm = {{52{sign}}, i_instr[31:25], i_instr[11:7]};
			FMT_B: o_imm = {{51{sign}}, i_instr[31], i_instr[7],
			                i_instr[30:25], i_instr[11:8], 1'b0};
			FMT_U: o_imm = {{32{sign}}, i_instr[31:12], 12'b0};
			FMT_J: o_imm = {{43{sign}}, i_instr[31], i_instr[19:12],
			                i_instr[20], i_instr[30:21], 1'b0};
			default: o_imm = '0; // R format has no immediate
		endcase
	end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module instr_decoder import id_pkg::*; (
	input  logic [`ILEN-1:0] i_instr,
	output id_ctrl_t         o_ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_base;
	logic       f7_alt;
	logic       imm32;     // OP-IMM-32
	logic       sh_base;   // immediate shift, logical form
	logic       sh_alt;    // immediate shift, arithmetic form
	logic       legal;

	assign opcode  = i_instr[`RNG_OPC];
	assign funct3  = i_instr[`RNG_F3];
	assign funct7  = i_instr[`RNG_F7];
	assign f7_base = (funct7 == `F7_BASE);
	assign f7_alt  = (funct7 == `F7_ALT);
	assign imm32   = (opcode == `OPC_OP_IMM_32);

	// RV64 shifts use a 6-bit shamt, the word forms the full funct7
	assign sh_base = imm32 ? f7_base : (i_instr[31:26] == `F6_BASE);
	assign sh_alt  = imm32 ? f7_alt  : (i_instr[31:26] == `F6_ALT);

	always_comb begin
		o_ctrl = '0;
		legal  = 1'b1;

		case (opcode)
			`OPC_LUI, `OPC_AUIPC: begin
				o_ctrl.fmt         = FMT_U;
				o_ctrl.alu_op      = (opcode == `OPC_LUI) ? ALU_LUI : ALU_AUIPC;
				o_ctrl.alu_src_imm = 1'b1;
				o_ctrl.rf_wr       = 1'b1;
			end
			`OPC_JAL, `OPC_JALR: begin
				o_ctrl.fmt         = (opcode == `OPC_JAL) ? FMT_J : FMT_I;
				o_ctrl.alu_op      = ALU_ADD; // link address
				o_ctrl.alu_src_imm = 1'b1;
				o_ctrl.is_branch   = 1'b1;
				o_ctrl.rf_wr       = 1'b1;
				if ((opcode == `OPC_JALR) && (funct3 != `F3_JALR))
					legal = 1'b0;
			end
			`OPC_BRANCH: begin
				o_ctrl.fmt       = FMT_B;
				o_ctrl.is_branch = 1'b1;
				case (funct3)
					`F3_BEQ, `F3_BNE, `F3_BLTU, `F3_BGEU: o_ctrl.alu_op = ALU_SUB;
					`F3_BLT: o_ctrl.alu_op = ALU_BLT;
					`F3_BGE: o_ctrl.alu_op = ALU_BGE;
					default: legal = 1'b0;
				endcase
			end
			`OPC_LOAD: begin
				o_ctrl.fmt          = FMT_I;
				o_ctrl.alu_op       = ALU_ADD; // address calc
				o_ctrl.alu_src_imm  = 1'b1;
				o_ctrl.mem_rd       = 1'b1;
				o_ctrl.rf_wr        = 1'b1;
				o_ctrl.mem_unsigned = funct3[2];
				case (funct3)
					`F3_LB, `F3_LBU: o_ctrl.mem_size = MEM_B;
					`F3_LH, `F3_LHU: o_ctrl.mem_size = MEM_H;
					`F3_LW, `F3_LWU: o_ctrl.mem_size = MEM_W;
					`F3_LD:          o_ctrl.mem_size = MEM_D;
					default:         legal = 1'b0;
				endcase
			end
			`OPC_STORE: begin
				o_ctrl.fmt         = FMT_S;
				o_ctrl.alu_op      = ALU_ADD;
				o_ctrl.alu_src_imm = 1'b1;
				o_ctrl.mem_wr      = 1'b1;
				case (funct3)
					`F3_SB:  o_ctrl.mem_size = MEM_B;
					`F3_SH:  o_ctrl.mem_size = MEM_H;
					`F3_SW:  o_ctrl.mem_size = MEM_W;
					`F3_SD:  o_ctrl.mem_size = MEM_D;
					default: legal = 1'b0;
				endcase
			end
			`OPC_OP_IMM, `OPC_OP_IMM_32: begin
				o_ctrl.fmt         = FMT_I;
				o_ctrl.alu_src_imm = 1'b1;
				o_ctrl.rf_wr       = 1'b1;
				o_ctrl.word_op     = imm32;
				case (funct3)
					`F3_ADD: o_ctrl.alu_op = ALU_ADD;
					`F3_SLL: begin
						o_ctrl.alu_op = ALU_SLL;
						legal         = sh_base;
					end
					`F3_SR: begin
						o_ctrl.alu_op = sh_alt ? ALU_SRA : ALU_SRL;
						legal         = sh_base || sh_alt;
					end
					`F3_SLT:  o_ctrl.alu_op = ALU_SLT;
					`F3_SLTU: o_ctrl.alu_op = ALU_SLTU;
					`F3_XOR:  o_ctrl.alu_op = ALU_XOR;
					`F3_OR:   o_ctrl.alu_op = ALU_OR;
					default:  o_ctrl.alu_op = ALU_AND;
				endcase
				// word form only has ADDIW and the shifts
				if (imm32 && !(funct3 inside {`F3_ADD, `F3_SLL, `F3_SR}))
					legal = 1'b0;
			end
			`OPC_OP, `OPC_OP_32: begin
				o_ctrl.fmt     = FMT_R;
				o_ctrl.rf_wr   = 1'b1;
				o_ctrl.word_op = (opcode == `OPC_OP_32);
				legal          = f7_base;
				case (funct3)
					`F3_ADD: begin
						o_ctrl.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
						legal         = f7_base || f7_alt;
					end
					`F3_SR: begin
						o_ctrl.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
						legal         = f7_base || f7_alt;
					end
					`F3_SLL:  o_ctrl.alu_op = ALU_SLL;
					`F3_SLT:  o_ctrl.alu_op = ALU_SLT;
					`F3_SLTU: o_ctrl.alu_op = ALU_SLTU;
					`F3_XOR:  o_ctrl.alu_op = ALU_XOR;
					`F3_OR:   o_ctrl.alu_op = ALU_OR;
					default:  o_ctrl.alu_op = ALU_AND;
				endcase
				if (o_ctrl.word_op && !(funct3 inside {`F3_ADD, `F3_SLL, `F3_SR}))
					legal = 1'b0;
			end
			default: legal = 1'b0; // unknown opcode
		endcase

		if (o_ctrl.rf_wr)
			o_ctrl.rd_addr = i_instr[`RNG_RD];
		o_ctrl.valid = 1'b1;

		// illegal encodings leave every field zero
		if (!legal)
			o_ctrl = '0;
	end

endmodule

// ==== logic/id_pipe_reg.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_pipe_reg import id_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_en,
	input  logic             i_flush,
	input  id_ctrl_t         i_ctrl,
	input  logic [`XLEN-1:0] i_pc,
	input  logic [`XLEN-1:0] i_rs1_data,
	input  logic [`XLEN-1:0] i_rs2_data,
	input  logic [`XLEN-1:0] i_imm,
	output id_ctrl_t         o_ctrl,
	output logic [`XLEN-1:0] o_pc,
	output logic [`XLEN-1:0] o_rs1_data,
	output logic [`XLEN-1:0] o_rs2_data,
	output logic [`XLEN-1:0] o_imm
);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			o_ctrl     <= '0;
			o_pc       <= '0;
			o_rs1_data <= '0;
			o_rs2_data <= '0;
			o_imm      <= '0;
		end else if (i_flush) begin // flush beats a load
			o_ctrl     <= '0;
			o_pc       <= '0;
			o_rs1_data <= '0;
			o_rs2_data <= '0;
			o_imm      <= '0;
		end else if (i_en) begin
			o_ctrl     <= i_ctrl;
			o_pc       <= i_pc;
			o_rs1_data <= i_rs1_data;
			o_rs2_data <= i_rs2_data;
			o_imm      <= i_imm;
		end
	end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage import id_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ILEN-1:0]   i_if_instr,
	input  logic [`XLEN-1:0]   i_if_pc,
	input  logic               i_ex_ready,
	input  logic               i_ex_flush_id,
	input  logic               i_wb_wr_en,
	input  logic [`REG_AW-1:0] i_wb_wr_addr,
	input  logic [`XLEN-1:0]   i_wb_wr_data,
	output logic               o_id_ready,
	output logic               o_valid,
	output logic [`XLEN-1:0]   o_pc,
	output logic [`XLEN-1:0]   o_rs1_data,
	output logic [`XLEN-1:0]   o_rs2_data,
	output logic [`XLEN-1:0]   o_imm,
	output alu_op_t            o_alu_op,
	output logic               o_alu_src_imm,
	output logic               o_is_branch,
	output logic               o_mem_rd,
	output logic               o_mem_wr,
	output mem_size_t          o_mem_size,
	output logic               o_mem_unsigned,
	output logic               o_rf_wr,
	output logic [`REG_AW-1:0] o_rd_addr,
	output logic               o_word_op
);

	id_ctrl_t         dec_ctrl; // decoder output, this cycle
	id_ctrl_t         ex_ctrl;  // registered toward execute
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] imm;

	assign o_id_ready = i_ex_ready;

	regfile_2r1w regfile_2r1w_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_raddr_a (i_if_instr[`RNG_RS1]),
		.i_raddr_b (i_if_instr[`RNG_RS2]),
		.i_wen     (i_wb_wr_en),
		.i_waddr   (i_wb_wr_addr),
		.i_wdata   (i_wb_wr_data),
		.o_rdata_a (rs1_data),
		.o_rdata_b (rs2_data)
	);

	instr_decoder instr_decoder_inst (
		.i_instr (i_if_instr),
		.o_ctrl  (dec_ctrl)
	);

	imm_gen imm_gen_inst (
		.i_instr (i_if_instr),
		.i_fmt   (dec_ctrl.fmt),
		.o_imm   (imm)
	);

	id_pipe_reg id_pipe_reg_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_en       (i_ex_ready),
		.i_flush    (i_ex_flush_id),
		.i_ctrl     (dec_ctrl),
		.i_pc       (i_if_pc),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_imm      (imm),
		.o_ctrl     (ex_ctrl),
		.o_pc       (o_pc),
		.o_rs1_data (o_rs1_data),
		.o_rs2_data (o_rs2_data),
		.o_imm      (o_imm)
	);

	// unpack onto the execute ports
	assign o_valid        = ex_ctrl.valid;
	assign o_alu_op       = ex_ctrl.alu_op;
	assign o_alu_src_imm  = ex_ctrl.alu_src_imm;
	assign o_is_branch    = ex_ctrl.is_branch;
	assign o_mem_rd       = ex_ctrl.mem_rd;
	assign o_mem_wr       = ex_ctrl.mem_wr;
	assign o_mem_size     = ex_ctrl.mem_size;
	assign o_mem_unsigned = ex_ctrl.mem_unsigned;
	assign o_rf_wr        = ex_ctrl.rf_wr;
	assign o_rd_addr      = ex_ctrl.rd_addr;
	assign o_word_op      = ex_ctrl.word_op;

endmodule

// ==== tb/tb_id_stage.sv ====
`timescale 1ns/10ps
`include "id_params.svh"

module tb_id_stage import id_pkg::*; ();

	logic               clk = 1'b0;
	logic               rst_n;
	logic [`ILEN-1:0]   i_if_instr;
	logic [`XLEN-1:0]   i_if_pc;
	logic               i_ex_ready;
	logic               i_ex_flush_id;
	logic               i_wb_wr_en;
	logic [`REG_AW-1:0] i_wb_wr_addr;
	logic [`XLEN-1:0]   i_wb_wr_data;
	logic               o_id_ready;
	logic               o_valid;
	logic [`XLEN-1:0]   o_pc;
	logic [`XLEN-1:0]   o_rs1_data;
	logic [`XLEN-1:0]   o_rs2_data;
	logic [`XLEN-1:0]   o_imm;
	alu_op_t            o_alu_op;
	logic               o_alu_src_imm;
	logic               o_is_branch;
	logic               o_mem_rd;
	logic               o_mem_wr;
	mem_size_t          o_mem_size;
	logic               o_mem_unsigned;
	logic               o_rf_wr;
	logic [`REG_AW-1:0] o_rd_addr;
	logic               o_word_op;

	id_ctrl_t         exp_ctrl; // expected pipeline register contents
	logic [`XLEN-1:0] exp_pc;
	logic [`XLEN-1:0] exp_rs1;
	logic [`XLEN-1:0] exp_rs2;
	logic [`XLEN-1:0] exp_imm;
	logic [`XLEN-1:0] rf_model [`NREGS];
	int               n_errors = 0;
	int               n_checks = 0;

	id_stage id_stage_inst (.*);

	always #10 clk = ~clk;

	// value sits in the top bits, arithmetic shift does the extension
	function automatic logic [63:0] sext(input logic [63:0] top, input int n);
		logic signed [63:0] s;
		s = top;
		return s >>> (64 - n);
	endfunction

	function automatic alu_op_t alu_for(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			`F3_SLL:  return ALU_SLL;
			`F3_SLT:  return ALU_SLT;
			`F3_SLTU: return ALU_SLTU;
			`F3_XOR:  return ALU_XOR;
			`F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			`F3_OR:   return ALU_OR;
			default:  return ALU_AND;
		endcase
	endfunction

	function automatic void ref_decode(input logic [31:0] ins, output id_ctrl_t c,
	                                   output logic [63:0] imm);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        word;
		logic        ok;
		logic [63:0] t;
		opc  = ins[6:0];
		f3   = ins[14:12];
		f7   = ins[31:25];
		word = (opc == `OPC_OP_IMM_32) || (opc == `OPC_OP_32);
		c    = '0;
		ok   = 1'b0;
		case (opc)
			`OPC_LUI, `OPC_AUIPC: begin
				ok            = 1'b1;
				c.fmt         = FMT_U;
				c.alu_op      = (opc == `OPC_LUI) ? ALU_LUI : ALU_AUIPC;
				c.alu_src_imm = 1'b1;
				c.rf_wr       = 1'b1;
			end
			`OPC_JAL, `OPC_JALR: begin
				ok            = (opc == `OPC_JAL) || (f3 == 3'd0);
				c.fmt         = (opc == `OPC_JAL) ? FMT_J : FMT_I;
				c.alu_op      = ALU_ADD;
				c.alu_src_imm = 1'b1;
				c.is_branch   = 1'b1;
				c.rf_wr       = 1'b1;
			end
			`OPC_BRANCH: begin
				ok          = (f3[2:1] != 2'b01); // funct3 2 and 3 unused
				c.fmt       = FMT_B;
				c.is_branch = 1'b1;
				c.alu_op    = (f3 == `F3_BLT) ? ALU_BLT : (f3 == `F3_BGE) ? ALU_BGE : ALU_SUB;
			end
			`OPC_LOAD, `OPC_STORE: begin
				c.alu_op      = ALU_ADD;
				c.alu_src_imm = 1'b1;
				c.mem_size    = mem_size_t'(f3[1:0]);
				if (opc == `OPC_LOAD) begin
					ok             = (f3 != 3'd7);
					c.fmt          = FMT_I;
					c.mem_rd       = 1'b1;
					c.rf_wr        = 1'b1;
					c.mem_unsigned = f3[2];
				end else begin
					ok       = !f3[2];
					c.fmt    = FMT_S;
					c.mem_wr = 1'b1;
				end
			end
			`OPC_OP_IMM, `OPC_OP_IMM_32: begin
				c.fmt         = FMT_I;
				c.alu_src_imm = 1'b1;
				c.rf_wr       = 1'b1;
				c.word_op     = word;
				c.alu_op      = alu_for(f3, (f3 == `F3_SR) && ins[30]);
				if (f3 == `F3_SLL)
					ok = word ? (f7 == `F7_BASE) : (ins[31:26] == 6'b000000);
				else if (f3 == `F3_SR)
					ok = word ? ((f7 == `F7_BASE) || (f7 == `F7_ALT)) :
					            ((ins[31:26] == 6'b000000) || (ins[31:26] == 6'b010000));
				else
					ok = !word || (f3 == `F3_ADD);
			end
			`OPC_OP, `OPC_OP_32: begin
				c.fmt     = FMT_R;
				c.rf_wr   = 1'b1;
				c.word_op = word;
				c.alu_op  = alu_for(f3, f7[5]);
				ok = (f7 == `F7_BASE) || ((f7 == `F7_ALT) && ((f3 == `F3_ADD) || (f3 == `F3_SR)));
				if (word && !((f3 == `F3_ADD) || (f3 == `F3_SLL) || (f3 == `F3_SR)))
					ok = 1'b0;
			end
			default: ok = 1'b0;
		endcase
		c.valid = 1'b1;
		if (c.rf_wr)
			c.rd_addr = ins[11:7];
		case (c.fmt)
			FMT_I:   t = sext({ins[31:20], 52'b0}, 12);
			FMT_S:   t = sext({ins[31:25], ins[11:7], 52'b0}, 12);
			FMT_B:   t = sext({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 51'b0}, 13);
			FMT_U:   t = sext({ins[31:12], 44'b0}, 32);
			FMT_J:   t = sext({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 43'b0}, 21);
			default: t = '0;
		endcase
		if (!ok) begin
			c = '0;
			t = '0;
		end
		imm = t;
	endfunction

	// random register and immediate fields around the given codes
	function automatic logic [31:0] enc(input logic [6:0] f7, input logic [2:0] f3,
	                                    input logic [6:0] opc);
		logic [31:0] r;
		r = $urandom;
		return {f7, r[24:20], r[19:15], f3, r[11:7], opc};
	endfunction

	function automatic logic [31:0] rand_legal(input int cls);
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r  = $urandom;
		f3 = r[14:12];
		f7 = r[31:25];
		case (cls)
			0: return enc(f7, f3, `OPC_LUI);
			1: return enc(f7, f3, `OPC_AUIPC);
			2: return enc(f7, f3, `OPC_JAL);
			3: return enc(f7, `F3_JALR, `OPC_JALR);
			4: begin
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1;
				return enc(f7, f3, `OPC_BRANCH);
			end
			5: return enc(f7, (f3 == 3'd7) ? `F3_LD : f3, `OPC_LOAD);
			6: return enc(f7, {1'b0, f3[1:0]}, `OPC_STORE);
			7: begin
				if (f3 == `F3_SLL)
					f7[6:1] = `F6_BASE;
				else if (f3 == `F3_SR)
					f7[6:1] = r[0] ? `F6_ALT : `F6_BASE;
				return enc(f7, f3, `OPC_OP_IMM);
			end
			8: return enc((r[0] && (f3 == `F3_ADD || f3 == `F3_SR)) ? `F7_ALT : `F7_BASE,
			              f3, `OPC_OP);
			9: begin
				f3 = (r[1:0] == 2'd0) ? `F3_ADD : (r[1:0] == 2'd1) ? `F3_SLL : `F3_SR;
				if (f3 != `F3_ADD)
					f7 = (r[2] && f3 == `F3_SR) ? `F7_ALT : `F7_BASE;
				return enc(f7, f3, `OPC_OP_IMM_32);
			end
			default: begin
				f3 = (r[1:0] == 2'd0) ? `F3_ADD : (r[1:0] == 2'd1) ? `F3_SLL : `F3_SR;
				return enc((r[2] && f3 != `F3_SLL) ? `F7_ALT : `F7_BASE, f3, `OPC_OP_32);
			end
		endcase
	endfunction

	function automatic logic [31:0] bad_instr(input int k);
		logic [31:0] r;
		r = $urandom;
		case (k)
			0:  return enc(r[31:25], 3'b001, `OPC_JALR);
			1:  return enc(r[31:25], 3'b010, `OPC_BRANCH);
			2:  return enc(r[31:25], 3'b011, `OPC_BRANCH);
			3:  return enc(r[31:25], 3'b111, `OPC_LOAD);
			4:  return enc(r[31:25], {1'b1, r[13:12]}, `OPC_STORE);
			5:  return enc(`F7_ALT, `F3_SLL, `OPC_OP_IMM);
			6:  return enc(7'b0000010, `F3_SR, `OPC_OP_IMM);    // stray bit in shift field
			7:  return enc(7'b0000001, r[14:12], `OPC_OP);       // M extension
			8:  return enc(`F7_ALT, `F3_XOR, `OPC_OP);
			9:  return enc(r[31:25], `F3_SLT, `OPC_OP_IMM_32);
			10: return enc(7'b0000001, `F3_SLL, `OPC_OP_IMM_32); // shamt bit 5
			11: return enc(7'b0000001, `F3_SR, `OPC_OP_IMM_32);
			12: return enc(7'b0100001, `F3_SR, `OPC_OP_IMM_32);
			13: return enc(`F7_BASE, `F3_OR, `OPC_OP_32);
			14: return enc(`F7_ALT, `F3_SLL, `OPC_OP_32);
			15: return enc(r[31:25], r[14:12], 7'b0001111);       // fence
			16: return enc(r[31:25], r[14:12], 7'b1110011);       // system
			default: return enc(r[31:25], r[14:12], 7'b0000000);
		endcase
	endfunction

	task automatic drive(input logic [31:0] ins, input logic rdy, input logic fl,
	                     input logic wen, input logic [4:0] waddr, input logic [63:0] wdata);
		@(posedge clk);
		i_if_instr    <= ins;
		i_if_pc       <= {$urandom, $urandom};
		i_ex_ready    <= rdy;
		i_ex_flush_id <= fl;
		i_wb_wr_en    <= wen;
		i_wb_wr_addr  <= waddr;
		i_wb_wr_data  <= wdata;
	endtask

	task automatic issue(input logic [31:0] ins);
		drive(ins, 1'b1, 1'b0, 1'b0, 5'd0, 64'd0);
	endtask

	task automatic wait_for_valid(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((o_valid !== level) && (n < max_cycles));
		if (o_valid !== level) begin
			$display("timeout: o_valid did not become %0b within %0d cycles waiting for %s",
			         level, max_cycles, what);
			n_errors++;
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
	                             input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			n_errors++;
		end
	endtask

	// expected state, follows each edge like the pipeline register
	always @(posedge clk, negedge rst_n) begin
		id_ctrl_t    dec;
		logic [63:0] imm;
		if (!rst_n) begin
			exp_ctrl <= '0;
			exp_pc   <= '0;
			exp_rs1  <= '0;
			exp_rs2  <= '0;
			exp_imm  <= '0;
			for (int i = 0; i < `NREGS; i++)
				rf_model[i] <= '0;
		end else begin
			ref_decode(i_if_instr, dec, imm);
			if (i_ex_flush_id) begin
				exp_ctrl <= '0;
				exp_pc   <= '0;
				exp_rs1  <= '0;
				exp_rs2  <= '0;
				exp_imm  <= '0;
			end else if (i_ex_ready) begin
				exp_ctrl <= dec;
				exp_pc   <= i_if_pc;
				exp_rs1  <= rf_model[i_if_instr[19:15]]; // old contents, no bypass
				exp_rs2  <= rf_model[i_if_instr[24:20]];
				exp_imm  <= imm;
			end
			if (i_wb_wr_en && (i_wb_wr_addr != 5'd0))
				rf_model[i_wb_wr_addr] <= i_wb_wr_data;
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			n_checks++;
			compare_value("o_valid", 64'(o_valid), 64'(exp_ctrl.valid));
			compare_value("o_pc", o_pc, exp_pc);
			compare_value("o_rs1_data", o_rs1_data, exp_rs1);
			compare_value("o_rs2_data", o_rs2_data, exp_rs2);
			compare_value("o_imm", o_imm, exp_imm);
			compare_value("o_alu_op", 64'(o_alu_op), 64'(exp_ctrl.alu_op));
			compare_value("o_alu_src_imm", 64'(o_alu_src_imm), 64'(exp_ctrl.alu_src_imm));
			compare_value("o_is_branch", 64'(o_is_branch), 64'(exp_ctrl.is_branch));
			compare_value("o_mem_rd", 64'(o_mem_rd), 64'(exp_ctrl.mem_rd));
			compare_value("o_mem_wr", 64'(o_mem_wr), 64'(exp_ctrl.mem_wr));
			compare_value("o_mem_size", 64'(o_mem_size), 64'(exp_ctrl.mem_size));
			compare_value("o_mem_unsigned", 64'(o_mem_unsigned), 64'(exp_ctrl.mem_unsigned));
			compare_value("o_rf_wr", 64'(o_rf_wr), 64'(exp_ctrl.rf_wr));
			compare_value("o_rd_addr", 64'(o_rd_addr), 64'(exp_ctrl.rd_addr));
			compare_value("o_word_op", 64'(o_word_op), 64'(exp_ctrl.word_op));
			compare_value("o_id_ready", 64'(o_id_ready), 64'(i_ex_ready));
		end
	end

	initial begin
		logic [63:0] saved_pc;
		logic [63:0] saved_imm;
		void'($urandom(32'h465a_182d));
		rst_n         <= 1'b0;
		i_if_instr    <= '0;
		i_if_pc       <= '0;
		i_ex_ready    <= 1'b0;
		i_ex_flush_id <= 1'b0;
		i_wb_wr_en    <= 1'b0;
		i_wb_wr_addr  <= '0;
		i_wb_wr_data  <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// every register reads zero after reset
		for (int r = 0; r < `NREGS; r++)
			issue({`F7_BASE, 5'(r), 5'(r), `F3_ADD, 5'd1, `OPC_OP});

		// fill the register file, x0 write must be dropped
		for (int r = 0; r < `NREGS; r++)
			drive(32'h0, 1'b1, 1'b0, 1'b1, 5'(r), {$urandom, $urandom});
		for (int i = 0; i < 24; i++) begin
			issue(enc(`F7_BASE, `F3_ADD, `OPC_OP));
			issue(enc(7'($urandom), `F3_SD, `OPC_STORE));
		end

		issue(32'h0);
		issue(enc({1'b1, 6'($urandom)}, `F3_ADD, `OPC_OP_IMM));
		wait_for_valid(1'b1, 4, "a negative ADDI");
		if (o_imm[63:31] !== '1) begin
			$display("FAILED at %0t: I-type immediate %h is not sign extended", $time, o_imm);
			n_errors++;
		end

		// legal encodings with writes at the same edges
		for (int i = 0; i < 400; i++)
			drive(rand_legal($urandom_range(10, 0)), 1'b1, 1'b0, 1'($urandom),
			      5'($urandom), {$urandom, $urandom});

		for (int k = 0; k < 36; k++)
			issue(bad_instr(k % 18));

		// back-pressure then flush against a high ready
		issue(32'h0);
		issue(rand_legal(7));
		wait_for_valid(1'b1, 4, "an instruction before the stall");
		saved_pc  = o_pc;
		saved_imm = o_imm;
		for (int i = 0; i < 5; i++) begin
			drive(rand_legal(8), 1'b0, 1'b0, 1'b0, 5'd0, 64'd0);
			@(negedge clk);
			if ((o_pc !== saved_pc) || (o_imm !== saved_imm) || (o_valid !== 1'b1)) begin
				$display("FAILED at %0t: outputs changed while execute was not ready", $time);
				n_errors++;
			end
		end
		drive(rand_legal(5), 1'b1, 1'b1, 1'b0, 5'd0, 64'd0);
		wait_for_valid(1'b0, 3, "the flush to clear the output");
		issue(rand_legal(0));
		issue(32'h0);
		wait_for_valid(1'b0, 4, "the pipeline to drain");

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== id_stage.f ====
+incdir+logic
logic/id_pkg.sv
logic/regfile_2r1w.sv
logic/imm_gen.sv
logic/instr_decoder.sv
logic/id_pipe_reg.sv
logic/id_stage.sv
tb/tb_id_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = tb_id_stage
FILELIST  = id_stage.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
